/* logic/fpu_mds_pkg.sv */
package fpu_mds_pkg;

    // IEEE 754 single format
    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;

    // Exponent field of infinities and NaNs
    localparam logic [EXP_WIDTH-1:0] EXP_ALL_ONES = 8'hff;

    // Canonical quiet NaN, positive with only the quiet bit set
    localparam logic [FP_WIDTH-1:0] DEFAULT_QNAN = 32'h7fc0_0000;

    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exponent;
        logic [FRAC_WIDTH-1:0] fraction;
    } fp32_t;

    // Operand class as seen by the special-case table
    // Subnormals count as finite nonzero numbers
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_signaling;
    } fp_class_t;

    typedef struct packed {
        logic overflow;
        logic invalid;
        logic div_by_zero;
    } fp_flags_t;

    // Fast result for special operands; hit marks a valid entry
    typedef struct packed {
        logic      hit;
        fp32_t     value;
        fp_flags_t flags;
    } fast_result_t;

    typedef enum logic [1:0] {
        op_mul      = 2'd0,
        op_div      = 2'd1,
        op_sqrt     = 2'd2,
        op_reserved = 2'd3
    } mds_op_e;

    // Source selected by the output register on load
    typedef enum logic [1:0] {
        src_fast = 2'd0,
        src_mul  = 2'd1,
        src_div  = 2'd2,
        src_sqrt = 2'd3
    } result_src_e;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_mul1      = 3'd1,
        st_mul2      = 3'd2,
        st_div_wait  = 3'd3,
        st_sqrt_wait = 3'd4
    } mds_state_e;

endpackage

/* logic/fpu_operand_classify.sv */
`timescale 1ns/1ns

module fpu_operand_classify
    import fpu_mds_pkg::*;
(
    input  fp32_t     operand,
    output fp_class_t operand_class
);

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;

    // Field decode
    assign exp_zero  = (operand.exponent == '0);
    assign exp_ones  = (operand.exponent == EXP_ALL_ONES);
    assign frac_zero = (operand.fraction == '0);

    assign operand_class.sign    = operand.sign;
    assign operand_class.is_zero = exp_zero & frac_zero;
    assign operand_class.is_inf  = exp_ones & frac_zero;
    assign operand_class.is_nan  = exp_ones & ~frac_zero;

    // Signaling NaN has the quiet bit clear
    assign operand_class.is_signaling = exp_ones & ~frac_zero
                                      & ~operand.fraction[FRAC_WIDTH-1];

endmodule

/* logic/fpu_special_case.sv */
`timescale 1ns/1ns

module fpu_special_case
    import fpu_mds_pkg::*;
(
    input  mds_op_e      op,
    input  fp32_t        a,
    input  fp32_t        b,
    input  fp_class_t    class_a,
    input  fp_class_t    class_b,
    output fast_result_t fast
);

    logic  sign_o;
    logic  nan_ab;
    logic  snan_ab;
    fp32_t nan_ab_value;

    // Propagated NaN keeps only its sign and the quiet bit
    function automatic fp32_t quiet_nan(input logic sign);
        fp32_t value;
        value.sign     = sign;
        value.exponent = EXP_ALL_ONES;
        value.fraction = '0;
        value.fraction[FRAC_WIDTH-1] = 1'b1;
        return value;
    endfunction

    function automatic fp32_t infinity(input logic sign);
        fp32_t value;
        value.sign     = sign;
        value.exponent = EXP_ALL_ONES;
        value.fraction = '0;
        return value;
    endfunction

    function automatic fp32_t signed_zero(input logic sign);
        fp32_t value;
        value          = '0;
        value.sign     = sign;
        return value;
    endfunction

    assign sign_o = class_a.sign ^ class_b.sign;

    // NaN handling shared by multiply and divide, A wins over B
    assign nan_ab       = class_a.is_nan | class_b.is_nan;
    assign snan_ab      = class_a.is_signaling | class_b.is_signaling;
    assign nan_ab_value = class_a.is_nan ? quiet_nan(a.sign) : quiet_nan(b.sign);

    always_comb begin
        fast = '0;
        case (op)
            op_mul: begin
                if (nan_ab) begin
                    fast.hit           = 1'b1;
                    fast.value         = nan_ab_value;
                    fast.flags.invalid = snan_ab;
                end else if ((class_a.is_zero && class_b.is_inf) ||
                             (class_a.is_inf && class_b.is_zero)) begin
                    fast.hit           = 1'b1;
                    fast.value         = DEFAULT_QNAN;
                    fast.flags.invalid = 1'b1;
                end else if (class_a.is_inf || class_b.is_inf) begin
                    fast.hit            = 1'b1;
                    fast.value          = infinity(sign_o);
                    fast.flags.overflow = 1'b1;
                end else if (class_a.is_zero || class_b.is_zero) begin
                    fast.hit   = 1'b1;
                    fast.value = signed_zero(sign_o);
                end
            end

            op_div: begin
                if (nan_ab) begin
                    fast.hit           = 1'b1;
                    fast.value         = nan_ab_value;
                    fast.flags.invalid = snan_ab;
                end else if (class_a.is_zero && class_b.is_zero) begin
                    fast.hit               = 1'b1;
                    fast.value             = DEFAULT_QNAN;
                    fast.flags.invalid     = 1'b1;
                    fast.flags.div_by_zero = 1'b1;
                end else if (class_a.is_inf && class_b.is_inf) begin
                    fast.hit           = 1'b1;
                    fast.value         = DEFAULT_QNAN;
                    fast.flags.invalid = 1'b1;
                end else if (class_a.is_inf) begin
                    // inf/0 also flags the zero divisor
                    fast.hit               = 1'b1;
                    fast.value             = infinity(sign_o);
                    fast.flags.overflow    = 1'b1;
                    fast.flags.div_by_zero = class_b.is_zero;
                end else if (class_b.is_zero) begin
                    fast.hit               = 1'b1;
                    fast.value             = infinity(sign_o);
                    fast.flags.overflow    = 1'b1;
                    fast.flags.div_by_zero = 1'b1;
                end else if (class_a.is_zero || class_b.is_inf) begin
                    fast.hit   = 1'b1;
                    fast.value = signed_zero(sign_o);
                end
            end

            op_sqrt: begin
                // Only A takes part, zero keeps its sign
                if (class_a.is_zero) begin
                    fast.hit   = 1'b1;
                    fast.value = signed_zero(class_a.sign);
                end else if (class_a.is_nan) begin
                    fast.hit           = 1'b1;
                    fast.value         = quiet_nan(a.sign);
                    fast.flags.invalid = class_a.is_signaling;
                end else if (class_a.sign) begin
                    fast.hit           = 1'b1;
                    fast.value         = DEFAULT_QNAN;
                    fast.flags.invalid = 1'b1;
                end else if (class_a.is_inf) begin
                    fast.hit            = 1'b1;
                    fast.value          = infinity(1'b0);
                    fast.flags.overflow = 1'b1;
                end
            end

            default: begin
                fast = '0;
            end
        endcase
    end

endmodule

/* logic/fpu_mds_sequencer.sv */
`timescale 1ns/1ns

module fpu_mds_sequencer
    import fpu_mds_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  mds_op_e     op,
    input  logic        fast_hit,
    input  logic        div_rdy,
    input  logic        sqrt_rdy,
    output logic        div_start,
    output logic        sqrt_start,
    output logic        load,
    output result_src_e src
);

    mds_state_e state;
    mds_state_e state_next;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        load       = 1'b0;
        src        = src_fast;
        case (state)
            st_idle: begin
                // Reserved opcode is not accepted
                if (start && op != op_reserved) begin
                    if (fast_hit) begin
                        load = 1'b1;
                    end else begin
                        case (op)
                            op_mul:  state_next = st_mul1;
                            op_div:  state_next = st_div_wait;
                            op_sqrt: state_next = st_sqrt_wait;
                            default: state_next = st_idle;
                        endcase
                    end
                end
            end

            st_mul1: begin
                state_next = st_mul2;
            end

            // Multiplier output is valid at the end of this cycle
            st_mul2: begin
                load       = 1'b1;
                src        = src_mul;
                state_next = st_idle;
            end

            st_div_wait: begin
                src = src_div;
                if (div_rdy) begin
                    load       = 1'b1;
                    state_next = st_idle;
                end
            end

            st_sqrt_wait: begin
                src = src_sqrt;
                if (sqrt_rdy) begin
                    load       = 1'b1;
                    state_next = st_idle;
                end
            end

            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Unit start is held for the whole wait, ready cycle included
    assign div_start  = (state == st_div_wait);
    assign sqrt_start = (state == st_sqrt_wait);

endmodule

/* logic/fpu_result_register.sv */
`timescale 1ns/1ns

module fpu_result_register
    import fpu_mds_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         load,
    input  result_src_e  src,
    input  fast_result_t fast,
    input  fp32_t        mul_result,
    input  fp32_t        div_result,
    input  fp32_t        sqrt_result,
    output fp32_t        result,
    output fp_flags_t    flags,
    output logic         done
);

    fp32_t     sel_value;
    fp_flags_t sel_flags;

    // Unit results never raise flags
    always_comb begin
        sel_flags = '0;
        case (src)
            src_fast: begin
                sel_value = fast.value;
                sel_flags = fast.flags;
            end
            src_mul:  sel_value = mul_result;
            src_div:  sel_value = div_result;
            default:  sel_value = sqrt_result;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= load;
            if (load) begin
                result <= sel_value;
                flags  <= sel_flags;
            end
        end
    end

endmodule

/* logic/fpu_mds_top.sv */
`timescale 1ns/1ns

module fpu_mds_top
    import fpu_mds_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start,
    input  mds_op_e   op,
    input  fp32_t     a,
    input  fp32_t     b,
    input  fp32_t     mul_result,
    input  logic      div_rdy,
    input  fp32_t     div_result,
    input  logic      sqrt_rdy,
    input  fp32_t     sqrt_result,
    output logic      div_start,
    output logic      sqrt_start,
    output fp32_t     result,
    output fp_flags_t flags,
    output logic      done
);

    fp_class_t    class_a;
    fp_class_t    class_b;
    fast_result_t fast;
    logic         load;
    result_src_e  src;

    fpu_operand_classify u_classify_a (
        .operand       (a),
        .operand_class (class_a)
    );

    fpu_operand_classify u_classify_b (
        .operand       (b),
        .operand_class (class_b)
    );

    fpu_special_case u_special_case (
        .op      (op),
        .a       (a),
        .b       (b),
        .class_a (class_a),
        .class_b (class_b),
        .fast    (fast)
    );

    fpu_mds_sequencer u_sequencer (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .op         (op),
        .fast_hit   (fast.hit),
        .div_rdy    (div_rdy),
        .sqrt_rdy   (sqrt_rdy),
        .div_start  (div_start),
        .sqrt_start (sqrt_start),
        .load       (load),
        .src        (src)
    );

    fpu_result_register u_result_register (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .src         (src),
        .fast        (fast),
        .mul_result  (mul_result),
        .div_result  (div_result),
        .sqrt_result (sqrt_result),
        .result      (result),
        .flags       (flags),
        .done        (done)
    );

endmodule

/* verification/fpu_mds_tb.sv */
`timescale 1ns/1ns

module fpu_mds_tb
    import fpu_mds_pkg::*;
();

    localparam int COLUMNS         = 6;
    localparam int MAX_PATTERNS    = 64;
    localparam int CYCLES_PER_TEST = 16;

    logic        clk;
    logic        reset;
    logic        start;
    mds_op_e     op;
    fp32_t       a;
    fp32_t       b;
    fp32_t       mul_result;
    logic        div_rdy;
    fp32_t       div_result;
    logic        sqrt_rdy;
    fp32_t       sqrt_result;
    logic        div_start;
    logic        sqrt_start;
    fp32_t       result;
    fp_flags_t   flags;
    logic        done;

    logic [31:0] patterns [0:COLUMNS*MAX_PATTERNS-1];
    logic [31:0] lfsr_state;
    string       test_label;
    int          pattern_count;
    int          error_count;
    int          check_count;
    int          cycle_count;
    int          timeout_limit;

    fpu_mds_top u_fpu_mds_top (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .a           (a),
        .b           (b),
        .mul_result  (mul_result),
        .div_rdy     (div_rdy),
        .div_result  (div_result),
        .sqrt_rdy    (sqrt_rdy),
        .sqrt_result (sqrt_result),
        .div_start   (div_start),
        .sqrt_start  (sqrt_start),
        .result      (result),
        .flags       (flags),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    // Extra wait cycles for a unit, 0 to 7
    task automatic draw_delay(output int delay);
        delay = 0;
        repeat (3) begin
            delay      = (delay << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %s %s: got %h expected %h", test_label, name, got, expected);
        end
    endtask

    // Sample point and drive point, 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic run_reserved(input int idx);
        int          base;
        int          errors_before;
        logic [31:0] hold_result;
        logic [2:0]  hold_flags;

        base          = idx * COLUMNS;
        errors_before = error_count;
        test_label    = $sformatf("test %0d", idx);
        hold_result   = result;
        hold_flags    = flags;
        op            = op_reserved;
        a             = patterns[base+1];
        b             = patterns[base+2];
        start         = 1'b1;
        repeat (4) begin
            next_cycle();
            start = 1'b0;
            check_value("done", done, 1'b0);
            check_value("div_start", div_start, 1'b0);
            check_value("sqrt_start", sqrt_start, 1'b0);
            check_value("result", result, hold_result);
            check_value("flags", flags, hold_flags);
        end
        $display("%s reserved op: %s", test_label,
                 (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    task automatic run_pattern(input int idx);
        int          base;
        int          latency;
        int          expect_latency;
        int          delay;
        int          errors_before;
        logic        unit_path;
        logic        seen_done;
        logic [31:0] unit_value;
        logic [31:0] expect_result;
        logic [2:0]  expect_flags;
        logic [31:0] hold_result;
        logic [2:0]  hold_flags;
        mds_op_e     op_value;

        base          = idx * COLUMNS;
        op_value      = mds_op_e'(patterns[base][1:0]);
        unit_value    = patterns[base+3];
        expect_result = patterns[base+4];
        expect_flags  = patterns[base+5][2:0];
        errors_before = error_count;
        test_label    = $sformatf("test %0d", idx);
        hold_result   = result;
        hold_flags    = flags;

        // A unit result with clear flags means the table has no entry
        unit_path = (expect_result == unit_value) && (expect_flags == 3'b000);
        delay     = 0;
        if (!unit_path) begin
            expect_latency = 1;
        end else if (op_value == op_mul) begin
            expect_latency = 3;
        end else begin
            draw_delay(delay);
            expect_latency = delay + 2;
        end

        op         = op_value;
        a          = patterns[base+1];
        b          = patterns[base+2];
        mul_result = (op_value == op_mul) ? unit_value : 32'h0;
        start      = 1'b1;
        latency    = 0;
        seen_done  = 1'b0;

        while (!seen_done) begin
            next_cycle();
            latency++;
            if (latency <= expect_latency) begin
                check_value("done", done, latency == expect_latency);
                check_value("div_start", div_start,
                            unit_path && op_value == op_div && latency < expect_latency);
                check_value("sqrt_start", sqrt_start,
                            unit_path && op_value == op_sqrt && latency < expect_latency);
            end
            if (done) begin
                seen_done = 1'b1;
                check_value("result", result, expect_result);
                check_value("flags", flags, expect_flags);
            end else begin
                check_value("result", result, hold_result);
                check_value("flags", flags, hold_flags);
            end
            // Second start while busy must be ignored
            start       = unit_path && (latency == 1);
            div_rdy     = unit_path && op_value == op_div && latency == expect_latency - 1;
            sqrt_rdy    = unit_path && op_value == op_sqrt && latency == expect_latency - 1;
            div_result  = div_rdy ? unit_value : 32'h0;
            sqrt_result = sqrt_rdy ? unit_value : 32'h0;
        end

        // done is a single pulse and the result holds
        next_cycle();
        check_value("done", done, 1'b0);
        check_value("result", result, expect_result);
        check_value("flags", flags, expect_flags);
        $display("%s op %0d a %h b %h latency %0d: %s", test_label, op_value, a, b,
                 latency, (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        cycle_count = 0;
        do begin
            @(posedge clk);
            cycle_count++;
        end while (cycle_count < timeout_limit);
        $display("Timeout: the tests did not finish within %0d cycles", timeout_limit);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        reset       = 1'b0;
        start       = 1'b0;
        op          = op_mul;
        a           = '0;
        b           = '0;
        mul_result  = '0;
        div_rdy     = 1'b0;
        div_result  = '0;
        sqrt_rdy    = 1'b0;
        sqrt_result = '0;
        lfsr_state  = 32'h3032_5f4b;
        error_count = 0;
        check_count = 0;

        // All-ones op word marks the end of the table
        for (int i = 0; i < COLUMNS * MAX_PATTERNS; i++) begin
            patterns[i] = 32'hffff_ffff;
        end
        $readmemh("verification/fpu_mds_patterns.txt", patterns);
        pattern_count = 0;
        while (pattern_count < MAX_PATTERNS &&
               patterns[pattern_count*COLUMNS] != 32'hffff_ffff) begin
            pattern_count++;
        end
        timeout_limit = pattern_count * CYCLES_PER_TEST + 20;
        if (pattern_count == 0) begin
            error_count++;
            $display("No patterns could be read from the pattern file");
        end

        repeat (4) @(posedge clk);
        #10;
        reset      = 1'b1;
        test_label = "reset";
        check_value("done", done, 1'b0);
        check_value("div_start", div_start, 1'b0);
        check_value("sqrt_start", sqrt_start, 1'b0);
        check_value("result", result, 32'h0);
        check_value("flags", flags, 3'h0);
        $display("reset: %s", (error_count == 0) ? "ok" : "FAILED");

        for (int i = 0; i < pattern_count; i++) begin
            if (patterns[i*COLUMNS][1:0] == op_reserved) begin
                run_reserved(i);
            end else begin
                run_pattern(i);
            end
        end

        $display("%0d tests, %0d checks, %0d failed", pattern_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verification/fpu_mds_patterns.txt */
// op a b unit_result expected_result expected_flags
// op 0 mul, 1 div, 2 sqrt, 3 reserved; flags bit 2 overflow, bit 1 invalid, bit 0 div_by_zero
// Multiply
0 ffc01234 3f800000 0badc0de ffc00000 0
0 7fc00000 ff800001 0badc0de 7fc00000 2
0 40000000 ff800001 0badc0de ffc00000 2
0 00000000 7f800000 0badc0de 7fc00000 2
0 ff800000 80000000 0badc0de 7fc00000 2
0 ff800000 40400000 0badc0de ff800000 4
0 c0000000 ff800000 0badc0de 7f800000 4
0 80000000 40490fdb 0badc0de 80000000 0
0 00000001 00000000 0badc0de 00000000 0
0 40000000 40400000 40c00000 40c00000 0
0 80000010 3f800000 80000010 80000010 0
// Divide
1 3f800000 7fa00000 0badc0de 7fc00000 2
1 80000000 00000000 0badc0de 7fc00000 3
1 7f800000 ff800000 0badc0de 7fc00000 2
1 7f800000 80000000 0badc0de ff800000 5
1 ff800000 c0000000 0badc0de 7f800000 4
1 40a00000 00000000 0badc0de 7f800000 5
1 00000000 ff800000 0badc0de 80000000 0
1 80000000 80000001 0badc0de 00000000 0
1 c1200000 7f800000 0badc0de 80000000 0
1 41200000 40000000 40a00000 40a00000 0
1 c0400000 3f000000 c0c00000 c0c00000 0
// Square root, b is not read
2 00000000 deadbeef 0badc0de 00000000 0
2 80000000 00000000 0badc0de 80000000 0
2 c0800000 00000000 0badc0de 7fc00000 2
2 ff800000 00000000 0badc0de 7fc00000 2
2 7f800000 00000000 0badc0de 7f800000 4
2 ff800001 00000000 0badc0de ffc00000 2
2 7fc00000 00000000 0badc0de 7fc00000 0
2 40800000 00000000 40000000 40000000 0
2 80000001 00000000 0badc0de 7fc00000 2
// Reserved op is ignored, then one more unit operation
3 40000000 40000000 00000000 00000000 0
2 41100000 00000000 40400000 40400000 0

/* src.f */
logic/fpu_mds_pkg.sv
logic/fpu_operand_classify.sv
logic/fpu_special_case.sv
logic/fpu_mds_sequencer.sv
logic/fpu_result_register.sv
logic/fpu_mds_top.sv
verification/fpu_mds_tb.sv

/* Bender.yml */
package:
  name: fpu_mds

sources:
  - files:
      - logic/fpu_mds_pkg.sv
      - logic/fpu_operand_classify.sv
      - logic/fpu_special_case.sv
      - logic/fpu_mds_sequencer.sv
      - logic/fpu_result_register.sv
      - logic/fpu_mds_top.sv
  - target: test
    files:
      - verification/fpu_mds_tb.sv
